/* hw/oooPkg.sv */
package oooPkg;

    // register values, results and result bus
    localparam int dataWidth = 32;

    // architectural register file
    localparam int regAddrWidth = 3;
    localparam int numRegs = 8;

    // load-immediate field, zero-extended to dataWidth
    localparam int immWidth = 16;

    // ALU operations
    typedef enum logic [2:0] {
        opAdd   = 3'd0,
        opSub   = 3'd1,
        opAnd   = 3'd2,
        opOr    = 3'd3,
        opXor   = 3'd4,
        opLoadI = 3'd5
    } aluOpE;

endpackage

/* hw/dispatcher.sv */
`timescale 1ns/10ps

module dispatcher #(
    parameter int RobDepth = 8,
    parameter int NumSlots = 4,
    localparam int TagWidth = $clog2(RobDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic instReq,
    output logic instAck,
    input  oooPkg::aluOpE instOp,
    input  logic [oooPkg::regAddrWidth-1:0] instRd,
    input  logic [oooPkg::regAddrWidth-1:0] instRs1,
    input  logic [oooPkg::regAddrWidth-1:0] instRs2,
    input  logic [oooPkg::immWidth-1:0] instImm,
    input  logic robFree,
    input  logic [TagWidth-1:0] allocTag,
    output logic allocEn,
    output logic [oooPkg::regAddrWidth-1:0] allocRd,
    output logic [TagWidth-1:0] readTagA,
    output logic [TagWidth-1:0] readTagB,
    input  logic readValidA,
    input  logic [oooPkg::dataWidth-1:0] readDataA,
    input  logic readValidB,
    input  logic [oooPkg::dataWidth-1:0] readDataB,
    output logic [oooPkg::regAddrWidth-1:0] rs1,
    output logic [oooPkg::regAddrWidth-1:0] rs2,
    input  logic [oooPkg::dataWidth-1:0] val1,
    input  logic busy1,
    input  logic [TagWidth-1:0] tag1,
    input  logic [oooPkg::dataWidth-1:0] val2,
    input  logic busy2,
    input  logic [TagWidth-1:0] tag2,
    output logic renameEn,
    output logic [oooPkg::regAddrWidth-1:0] renameRd,
    output logic [TagWidth-1:0] renameTag,
    input  logic [NumSlots-1:0] slotIdle,
    output logic [NumSlots-1:0] slotLoad,
    output oooPkg::aluOpE loadOp,
    output logic [oooPkg::dataWidth-1:0] loadValA,
    output logic [oooPkg::dataWidth-1:0] loadValB,
    output logic loadRdyA,
    output logic loadRdyB,
    output logic [TagWidth-1:0] loadTagA,
    output logic [TagWidth-1:0] loadTagB,
    output logic [TagWidth-1:0] loadTag
);

    typedef enum logic {waitReq, waitDrop} hsStateE;

    hsStateE state;
    logic [NumSlots-1:0] slotPick;
    logic slotFound;
    logic dispatch;

    // lowest idle slot, one-hot
    always_comb begin
        slotPick = '0;
        slotFound = 1'b0;
        for (int i = 0; i < NumSlots; i++) begin
            if (slotIdle[i] && !slotFound) begin
                slotPick[i] = 1'b1;
                slotFound = 1'b1;
            end
        end
    end

    assign dispatch = (state == waitReq) && instReq && robFree && slotFound;

    assign slotLoad = dispatch ? slotPick : '0;
    assign allocEn = dispatch;
    assign allocRd = instRd;
    assign renameEn = dispatch;
    assign renameRd = instRd;
    assign renameTag = allocTag;
    assign loadTag = allocTag;
    assign loadOp = instOp;

    // register file lookup, then forwarding by the rename tag
    assign rs1 = instRs1;
    assign rs2 = instRs2;
    assign readTagA = tag1;
    assign readTagB = tag2;
    assign loadTagA = tag1;
    assign loadTagB = tag2;

    always_comb begin
        loadRdyA = 1'b1;
        loadRdyB = 1'b1;
        if (instOp == oooPkg::opLoadI) begin
            loadValA = {{(oooPkg::dataWidth - oooPkg::immWidth){1'b0}}, instImm};
            loadValB = '0;
        end else begin
            if (!busy1) begin
                loadValA = val1;
            end else if (readValidA) begin
                loadValA = readDataA;
            end else begin
                // wait on tag1 in the slot
                loadValA = '0;
                loadRdyA = 1'b0;
            end
            if (!busy2) begin
                loadValB = val2;
            end else if (readValidB) begin
                loadValB = readDataB;
            end else begin
                loadValB = '0;
                loadRdyB = 1'b0;
            end
        end
    end

    // four-phase handshake on the instruction port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= waitReq;
            instAck <= 1'b0;
        end else begin
            case (state)
                waitReq: begin
                    if (dispatch) begin
                        state <= waitDrop;
                        instAck <= 1'b1;
                    end
                end
                waitDrop: begin
                    if (!instReq) begin
                        state <= waitReq;
                        instAck <= 1'b0;
                    end
                end
                default: state <= waitReq;
            endcase
        end
    end

endmodule

/* hw/issueSlot.sv */
`timescale 1ns/10ps

module issueSlot #(
    parameter int RobDepth = 8,
    localparam int TagWidth = $clog2(RobDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic slotLoad,
    input  oooPkg::aluOpE loadOp,
    input  logic [oooPkg::dataWidth-1:0] loadValA,
    input  logic [oooPkg::dataWidth-1:0] loadValB,
    input  logic loadRdyA,
    input  logic loadRdyB,
    input  logic [TagWidth-1:0] loadTagA,
    input  logic [TagWidth-1:0] loadTagB,
    input  logic [TagWidth-1:0] loadTag,
    input  logic resValid,
    input  logic [TagWidth-1:0] resTag,
    input  logic [oooPkg::dataWidth-1:0] resData,
    input  logic slotGrant,
    output logic slotIdle,
    output logic slotDone,
    output logic [TagWidth-1:0] slotTag,
    output logic [oooPkg::dataWidth-1:0] slotResult
);

    typedef enum logic [1:0] {idle, waitOps, done} slotStateE;

    slotStateE state;
    oooPkg::aluOpE op;
    logic [oooPkg::dataWidth-1:0] valA;
    logic [oooPkg::dataWidth-1:0] valB;
    logic [TagWidth-1:0] tagA;
    logic [TagWidth-1:0] tagB;
    logic rdyA;
    logic rdyB;
    logic hitA;
    logic hitB;

    // snoop the result bus for a missing operand
    assign hitA = (state == waitOps) && !rdyA && resValid && (resTag == tagA);
    assign hitB = (state == waitOps) && !rdyB && resValid && (resTag == tagB);

    assign slotIdle = (state == idle);
    assign slotDone = (state == done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            rdyA <= 1'b0;
            rdyB <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (slotLoad) begin
                        rdyA <= loadRdyA;
                        rdyB <= loadRdyB;
                        state <= (loadRdyA && loadRdyB) ? done : waitOps;
                    end
                end
                waitOps: begin
                    if (hitA) rdyA <= 1'b1;
                    if (hitB) rdyB <= 1'b1;
                    if ((rdyA || hitA) && (rdyB || hitB)) state <= done;
                end
                done: begin
                    if (slotGrant) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (slotLoad && state == idle) begin
            op <= loadOp;
            valA <= loadValA;
            valB <= loadValB;
            tagA <= loadTagA;
            tagB <= loadTagB;
            slotTag <= loadTag;
        end else begin
            if (hitA) valA <= resData;
            if (hitB) valB <= resData;
        end
    end

    // single-cycle ALU
    always_comb begin
        case (op)
            oooPkg::opAdd:   slotResult = valA + valB;
            oooPkg::opSub:   slotResult = valA - valB;
            oooPkg::opAnd:   slotResult = valA & valB;
            oooPkg::opOr:    slotResult = valA | valB;
            oooPkg::opXor:   slotResult = valA ^ valB;
            oooPkg::opLoadI: slotResult = valA;
            default:         slotResult = '0;
        endcase
    end

endmodule

/* hw/resultArbiter.sv */
`timescale 1ns/10ps

module resultArbiter #(
    parameter int RobDepth = 8,
    parameter int NumSlots = 4,
    localparam int TagWidth = $clog2(RobDepth),
    localparam int SlotIdxW = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
    input  logic clk,
    input  logic rst,
    input  logic [NumSlots-1:0] slotDone,
    input  logic [NumSlots*TagWidth-1:0] slotTag,
    input  logic [NumSlots*oooPkg::dataWidth-1:0] slotResult,
    output logic [NumSlots-1:0] slotGrant,
    output logic resValid,
    output logic [TagWidth-1:0] resTag,
    output logic [oooPkg::dataWidth-1:0] resData
);

    logic [SlotIdxW-1:0] lastPtr;
    logic [SlotIdxW-1:0] pick;

    // search starts one past the last granted slot
    always_comb begin
        int idx;
        slotGrant = '0;
        resValid = 1'b0;
        pick = '0;
        for (int i = 1; i <= NumSlots; i++) begin
            idx = (int'(lastPtr) + i) % NumSlots;
            if (!resValid && slotDone[idx]) begin
                resValid = 1'b1;
                pick = SlotIdxW'(idx);
            end
        end
        if (resValid) slotGrant[pick] = 1'b1;
    end

    assign resTag = slotTag[pick*TagWidth +: TagWidth];
    assign resData = slotResult[pick*oooPkg::dataWidth +: oooPkg::dataWidth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lastPtr <= '0;
        end else if (resValid) begin
            lastPtr <= pick;
        end
    end

endmodule

/* hw/reorderBuffer.sv */
`timescale 1ns/10ps

module reorderBuffer #(
    parameter int RobDepth = 8,
    localparam int TagWidth = $clog2(RobDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic allocEn,
    input  logic [oooPkg::regAddrWidth-1:0] allocRd,
    output logic [TagWidth-1:0] allocTag,
    output logic robFree,
    input  logic resValid,
    input  logic [TagWidth-1:0] resTag,
    input  logic [oooPkg::dataWidth-1:0] resData,
    input  logic [TagWidth-1:0] readTagA,
    input  logic [TagWidth-1:0] readTagB,
    output logic readValidA,
    output logic [oooPkg::dataWidth-1:0] readDataA,
    output logic readValidB,
    output logic [oooPkg::dataWidth-1:0] readDataB,
    output logic commitValid,
    output logic [TagWidth-1:0] commitTag,
    output logic [oooPkg::regAddrWidth-1:0] commitRd,
    output logic [oooPkg::dataWidth-1:0] commitData
);

    logic [TagWidth-1:0] head;
    logic [TagWidth-1:0] tail;
    logic [TagWidth:0] count;
    logic [RobDepth-1:0] written;
    logic [oooPkg::regAddrWidth-1:0] destRd [RobDepth];
    logic [oooPkg::dataWidth-1:0] entryData [RobDepth];
    logic commitFire;

    // tail is the next free entry
    assign allocTag = tail;
    assign robFree = (count < RobDepth);
    assign commitFire = (count != '0) && written[head];

    // stored result, or the result bus in the same cycle
    assign readValidA = written[readTagA] || (resValid && resTag == readTagA);
    assign readDataA = (resValid && resTag == readTagA) ? resData : entryData[readTagA];
    assign readValidB = written[readTagB] || (resValid && resTag == readTagB);
    assign readDataB = (resValid && resTag == readTagB) ? resData : entryData[readTagB];

    // the written flag clears on allocation, not on commit, so the committed
    // value is still readable while the register file takes the update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            written <= '0;
            commitValid <= 1'b0;
        end else begin
            if (allocEn) begin
                written[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (resValid) written[resTag] <= 1'b1;
            commitValid <= commitFire;
            if (commitFire) head <= head + 1'b1;
            case ({allocEn, commitFire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) destRd[tail] <= allocRd;
        if (resValid) entryData[resTag] <= resData;
    end

    // commit payload, qualified by commitValid
    always_ff @(posedge clk) begin
        if (commitFire) begin
            commitTag <= head;
            commitRd <= destRd[head];
            commitData <= entryData[head];
        end
    end

endmodule

/* hw/registerFile.sv */
`timescale 1ns/10ps

module registerFile #(
    parameter int RobDepth = 8,
    localparam int TagWidth = $clog2(RobDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic [oooPkg::regAddrWidth-1:0] rs1,
    input  logic [oooPkg::regAddrWidth-1:0] rs2,
    output logic [oooPkg::dataWidth-1:0] val1,
    output logic busy1,
    output logic [TagWidth-1:0] tag1,
    output logic [oooPkg::dataWidth-1:0] val2,
    output logic busy2,
    output logic [TagWidth-1:0] tag2,
    input  logic renameEn,
    input  logic [oooPkg::regAddrWidth-1:0] renameRd,
    input  logic [TagWidth-1:0] renameTag,
    input  logic commitValid,
    input  logic [TagWidth-1:0] commitTag,
    input  logic [oooPkg::regAddrWidth-1:0] commitRd,
    input  logic [oooPkg::dataWidth-1:0] commitData
);

    logic [oooPkg::dataWidth-1:0] regVal [oooPkg::numRegs];
    logic [TagWidth-1:0] regTag [oooPkg::numRegs];
    logic [oooPkg::numRegs-1:0] regBusy;

    assign val1 = regVal[rs1];
    assign busy1 = regBusy[rs1];
    assign tag1 = regTag[rs1];
    assign val2 = regVal[rs2];
    assign busy2 = regBusy[rs2];
    assign tag2 = regTag[rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regBusy <= '0;
            for (int i = 0; i < oooPkg::numRegs; i++) begin
                regVal[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            if (commitValid) begin
                regVal[commitRd] <= commitData;
                // an older producer must not clear a newer rename
                if (regTag[commitRd] == commitTag) regBusy[commitRd] <= 1'b0;
            end
            // rename wins over a commit to the same register
            if (renameEn) begin
                regBusy[renameRd] <= 1'b1;
                regTag[renameRd] <= renameTag;
            end
        end
    end

endmodule

/* hw/oooCore.sv */
`timescale 1ns/10ps

module oooCore #(
    parameter int RobDepth = 8,
    parameter int NumSlots = 4,
    localparam int TagWidth = $clog2(RobDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic instReq,
    output logic instAck,
    input  oooPkg::aluOpE instOp,
    input  logic [oooPkg::regAddrWidth-1:0] instRd,
    input  logic [oooPkg::regAddrWidth-1:0] instRs1,
    input  logic [oooPkg::regAddrWidth-1:0] instRs2,
    input  logic [oooPkg::immWidth-1:0] instImm,
    output logic commitValid,
    output logic [TagWidth-1:0] commitTag,
    output logic [oooPkg::regAddrWidth-1:0] commitRd,
    output logic [oooPkg::dataWidth-1:0] commitData
);

    localparam int DW = oooPkg::dataWidth;
    localparam int AW = oooPkg::regAddrWidth;

    // allocation and forwarding
    logic robFree;
    logic allocEn;
    logic [TagWidth-1:0] allocTag;
    logic [AW-1:0] allocRd;
    logic [TagWidth-1:0] readTagA;
    logic [TagWidth-1:0] readTagB;
    logic readValidA;
    logic readValidB;
    logic [DW-1:0] readDataA;
    logic [DW-1:0] readDataB;

    // register file read and rename
    logic [AW-1:0] rs1;
    logic [AW-1:0] rs2;
    logic [DW-1:0] val1;
    logic [DW-1:0] val2;
    logic busy1;
    logic busy2;
    logic [TagWidth-1:0] tag1;
    logic [TagWidth-1:0] tag2;
    logic renameEn;
    logic [AW-1:0] renameRd;
    logic [TagWidth-1:0] renameTag;

    // slot load bundle
    logic [NumSlots-1:0] slotIdle;
    logic [NumSlots-1:0] slotLoad;
    oooPkg::aluOpE loadOp;
    logic [DW-1:0] loadValA;
    logic [DW-1:0] loadValB;
    logic loadRdyA;
    logic loadRdyB;
    logic [TagWidth-1:0] loadTagA;
    logic [TagWidth-1:0] loadTagB;
    logic [TagWidth-1:0] loadTag;

    // slots to arbiter, result bus
    logic [NumSlots-1:0] slotDone;
    logic [NumSlots-1:0] slotGrant;
    logic [NumSlots*TagWidth-1:0] slotTag;
    logic [NumSlots*DW-1:0] slotResult;
    logic resValid;
    logic [TagWidth-1:0] resTag;
    logic [DW-1:0] resData;

    dispatcher #(.RobDepth(RobDepth), .NumSlots(NumSlots)) dispatcher_i (
        .clk(clk), .rst(rst),
        .instReq(instReq), .instAck(instAck), .instOp(instOp),
        .instRd(instRd), .instRs1(instRs1), .instRs2(instRs2), .instImm(instImm),
        .robFree(robFree), .allocTag(allocTag), .allocEn(allocEn), .allocRd(allocRd),
        .readTagA(readTagA), .readTagB(readTagB),
        .readValidA(readValidA), .readDataA(readDataA),
        .readValidB(readValidB), .readDataB(readDataB),
        .rs1(rs1), .rs2(rs2),
        .val1(val1), .busy1(busy1), .tag1(tag1),
        .val2(val2), .busy2(busy2), .tag2(tag2),
        .renameEn(renameEn), .renameRd(renameRd), .renameTag(renameTag),
        .slotIdle(slotIdle), .slotLoad(slotLoad),
        .loadOp(loadOp), .loadValA(loadValA), .loadValB(loadValB),
        .loadRdyA(loadRdyA), .loadRdyB(loadRdyB),
        .loadTagA(loadTagA), .loadTagB(loadTagB), .loadTag(loadTag)
    );

    for (genvar s = 0; s < NumSlots; s++) begin : gSlot
        issueSlot #(.RobDepth(RobDepth)) slot_i (
            .clk(clk), .rst(rst),
            .slotLoad(slotLoad[s]),
            .loadOp(loadOp), .loadValA(loadValA), .loadValB(loadValB),
            .loadRdyA(loadRdyA), .loadRdyB(loadRdyB),
            .loadTagA(loadTagA), .loadTagB(loadTagB), .loadTag(loadTag),
            .resValid(resValid), .resTag(resTag), .resData(resData),
            .slotGrant(slotGrant[s]), .slotIdle(slotIdle[s]), .slotDone(slotDone[s]),
            .slotTag(slotTag[s*TagWidth +: TagWidth]),
            .slotResult(slotResult[s*DW +: DW])
        );
    end

    resultArbiter #(.RobDepth(RobDepth), .NumSlots(NumSlots)) arbiter_i (
        .clk(clk), .rst(rst),
        .slotDone(slotDone), .slotTag(slotTag), .slotResult(slotResult),
        .slotGrant(slotGrant),
        .resValid(resValid), .resTag(resTag), .resData(resData)
    );

    reorderBuffer #(.RobDepth(RobDepth)) rob_i (
        .clk(clk), .rst(rst),
        .allocEn(allocEn), .allocRd(allocRd), .allocTag(allocTag), .robFree(robFree),
        .resValid(resValid), .resTag(resTag), .resData(resData),
        .readTagA(readTagA), .readTagB(readTagB),
        .readValidA(readValidA), .readDataA(readDataA),
        .readValidB(readValidB), .readDataB(readDataB),
        .commitValid(commitValid), .commitTag(commitTag),
        .commitRd(commitRd), .commitData(commitData)
    );

    registerFile #(.RobDepth(RobDepth)) regFile_i (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2),
        .val1(val1), .busy1(busy1), .tag1(tag1),
        .val2(val2), .busy2(busy2), .tag2(tag2),
        .renameEn(renameEn), .renameRd(renameRd), .renameTag(renameTag),
        .commitValid(commitValid), .commitTag(commitTag),
        .commitRd(commitRd), .commitData(commitData)
    );

endmodule

/* test/oooCoreTb.sv */
`timescale 1ns/10ps

module oooCoreTb;

    localparam int RobDepth = 8;
    localparam int NumSlots = 4;
    localparam int TagWidth = $clog2(RobDepth);
    localparam int ClkPeriod = 40;
    localparam int CyclesPerEntry = 40;
    localparam int ResetCycles = 2;
    localparam int DW = oooPkg::dataWidth;
    localparam int AW = oooPkg::regAddrWidth;

    logic clk;
    logic rst;
    logic instReq;
    logic instAck;
    oooPkg::aluOpE instOp;
    logic [AW-1:0] instRd;
    logic [AW-1:0] instRs1;
    logic [AW-1:0] instRs2;
    logic [oooPkg::immWidth-1:0] instImm;
    logic commitValid;
    logic [TagWidth-1:0] commitTag;
    logic [AW-1:0] commitRd;
    logic [DW-1:0] commitData;

    // program table, expected columns filled by the reference model
    int tblTest [$];
    oooPkg::aluOpE tblOp [$];
    logic [AW-1:0] tblRd [$];
    logic [AW-1:0] tblRs1 [$];
    logic [AW-1:0] tblRs2 [$];
    logic [oooPkg::immWidth-1:0] tblImm [$];
    logic [AW-1:0] expRd [$];
    logic [DW-1:0] expData [$];
    string testName [1:5];

    bit tableReady;
    int sentCount;
    int checkedCount;
    int errorCount;
    int testErrors [1:5];
    int testsPassed;
    int testsFailed;

    oooCore #(.RobDepth(RobDepth), .NumSlots(NumSlots)) dut_i (
        .clk(clk), .rst(rst),
        .instReq(instReq), .instAck(instAck), .instOp(instOp),
        .instRd(instRd), .instRs1(instRs1), .instRs2(instRs2), .instImm(instImm),
        .commitValid(commitValid), .commitTag(commitTag),
        .commitRd(commitRd), .commitData(commitData)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic addEntry(input int test, input oooPkg::aluOpE op, input int rd,
                            input int rs1, input int rs2, input int imm);
        tblTest.push_back(test);
        tblOp.push_back(op);
        tblRd.push_back(AW'(rd));
        tblRs1.push_back(AW'(rs1));
        tblRs2.push_back(AW'(rs2));
        tblImm.push_back(oooPkg::immWidth'(imm));
    endtask

    task automatic buildTable();
        testName[1] = "add of reset registers";
        testName[2] = "alu ops after load-immediate";
        testName[3] = "dependent chain";
        testName[4] = "repeated writes then read";
        testName[5] = "back-to-back load-immediates";
        addEntry(1, oooPkg::opAdd, 2, 0, 1, 0);
        addEntry(2, oooPkg::opLoadI, 1, 0, 0, 'h1234);
        addEntry(2, oooPkg::opLoadI, 2, 0, 0, 'h00ff);
        addEntry(2, oooPkg::opAdd, 3, 1, 2, 0);
        addEntry(2, oooPkg::opSub, 4, 2, 1, 0);
        addEntry(2, oooPkg::opAnd, 5, 1, 2, 0);
        addEntry(2, oooPkg::opOr, 6, 1, 2, 0);
        addEntry(2, oooPkg::opXor, 7, 1, 2, 0);
        // each one reads the previous destination
        addEntry(3, oooPkg::opLoadI, 1, 0, 0, 'h0005);
        addEntry(3, oooPkg::opAdd, 1, 1, 1, 0);
        addEntry(3, oooPkg::opAdd, 1, 1, 1, 0);
        addEntry(3, oooPkg::opXor, 2, 1, 3, 0);
        addEntry(3, oooPkg::opSub, 3, 2, 1, 0);
        addEntry(3, oooPkg::opOr, 4, 3, 2, 0);
        addEntry(4, oooPkg::opLoadI, 5, 0, 0, 'h0011);
        addEntry(4, oooPkg::opLoadI, 5, 0, 0, 'h0022);
        addEntry(4, oooPkg::opLoadI, 5, 0, 0, 'h0033);
        addEntry(4, oooPkg::opAdd, 6, 5, 5, 0);
        for (int i = 0; i < 10; i++) begin
            addEntry(5, oooPkg::opLoadI, i % 8, 0, 0, 'ha000 + i * 'h111);
        end
    endtask

    function automatic logic [DW-1:0] modelResult(input oooPkg::aluOpE op,
                                                  input logic [DW-1:0] a,
                                                  input logic [DW-1:0] b,
                                                  input logic [oooPkg::immWidth-1:0] imm);
        logic [DW-1:0] r;
        case (op)
            oooPkg::opAdd:   r = a + b;
            oooPkg::opSub:   r = a - b;
            oooPkg::opAnd:   r = a & b;
            oooPkg::opOr:    r = a | b;
            oooPkg::opXor:   r = a ^ b;
            oooPkg::opLoadI: r = DW'(imm);
            default:         r = '0;
        endcase
        return r;
    endfunction

    // sequential model over the architectural registers
    task automatic buildExpected();
        logic [DW-1:0] refRegs [oooPkg::numRegs];
        logic [DW-1:0] r;
        for (int i = 0; i < oooPkg::numRegs; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < tblOp.size(); i++) begin
            r = modelResult(tblOp[i], refRegs[tblRs1[i]], refRegs[tblRs2[i]], tblImm[i]);
            refRegs[tblRd[i]] = r;
            expRd.push_back(tblRd[i]);
            expData.push_back(r);
        end
    endtask

    // one four-phase transfer, starting on the current rising edge
    task automatic sendInst(input int idx);
        instOp <= tblOp[idx];
        instRd <= tblRd[idx];
        instRs1 <= tblRs1[idx];
        instRs2 <= tblRs2[idx];
        instImm <= tblImm[idx];
        instReq <= 1'b1;
        do @(posedge clk); while (!instAck);
        sentCount++;
        instReq <= 1'b0;
        do @(posedge clk); while (instAck);
    endtask

    task automatic countError(input int idx);
        errorCount++;
        if (idx >= 0) testErrors[tblTest[idx]]++;
    endtask

    task automatic finishEntry(input int idx);
        int t;
        t = tblTest[idx];
        if (idx == tblTest.size() - 1 || tblTest[idx + 1] != t) begin
            if (testErrors[t] == 0) begin
                testsPassed++;
                $display("test %0d (%s): pass", t, testName[t]);
            end else begin
                testsFailed++;
                $display("test %0d (%s): fail, %0d bad checks", t, testName[t], testErrors[t]);
            end
        end
    endtask

    task automatic checkCommit();
        int idx;
        logic [TagWidth-1:0] tagExp;
        idx = checkedCount;
        if (sentCount == 0) begin
            $display("commit seen before any instruction was accepted");
            countError(-1);
        end else if (idx >= tblOp.size()) begin
            $display("extra commit after the last instruction, tag 0x%h", commitTag);
            countError(-1);
        end else if (idx >= sentCount) begin
            $display("commit for instruction %0d before it was accepted", idx);
            countError(idx);
        end else begin
            tagExp = TagWidth'(idx % RobDepth);
            if (commitTag !== tagExp) begin
                $display("mismatch entry %0d commitTag expected 0x%h got 0x%h",
                         idx, tagExp, commitTag);
                countError(idx);
            end
            if (commitRd !== expRd[idx]) begin
                $display("mismatch entry %0d commitRd expected 0x%h got 0x%h",
                         idx, expRd[idx], commitRd);
                countError(idx);
            end
            if (commitData !== expData[idx]) begin
                $display("mismatch entry %0d commitData expected 0x%h got 0x%h",
                         idx, expData[idx], commitData);
                countError(idx);
            end
            checkedCount++;
            finishEntry(idx);
        end
    endtask

    // commit outputs are stable at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && commitValid === 1'b1) checkCommit();
        end
    end

    initial begin
        wait (tableReady);
        #((tblOp.size() * CyclesPerEntry + ResetCycles) * ClkPeriod);
        $display("timeout: %0d of %0d commits checked, %0d instructions accepted",
                 checkedCount, tblOp.size(), sentCount);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int gap;
        rst = 1'b1;
        instReq = 1'b0;
        instOp = oooPkg::opAdd;
        instRd = '0;
        instRs1 = '0;
        instRs2 = '0;
        instImm = '0;
        void'($urandom(32'ha696_d48a));
        buildTable();
        buildExpected();
        tableReady = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < tblOp.size(); i++) begin
            // test 5 runs without idle gaps
            if (tblTest[i] != 5) begin
                gap = int'($urandom % 4);
                repeat (gap) @(posedge clk);
            end
            sendInst(i);
        end
        wait (checkedCount == tblOp.size());
        // room for a stray extra commit to show up
        repeat (10) @(posedge clk);
        $display("tests passed %0d, tests failed %0d, commits checked %0d, bad checks %0d",
                 testsPassed, testsFailed, checkedCount, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/oooPkg.sv
hw/dispatcher.sv
hw/issueSlot.sv
hw/resultArbiter.sv
hw/reorderBuffer.sv
hw/registerFile.sv
hw/oooCore.sv
test/oooCoreTb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - files:
      - hw/oooPkg.sv
      - hw/dispatcher.sv
      - hw/issueSlot.sv
      - hw/resultArbiter.sv
      - hw/reorderBuffer.sv
      - hw/registerFile.sv
      - hw/oooCore.sv
  - target: test
    files:
      - test/oooCoreTb.sv
